// ==== source/x11_regmap_pkg.sv ====
package x11_regmap_pkg;

  // --------------------
  // register map, 20 bit bus offsets

  parameter logic [19:0] ADDR_CTRL           = 20'h00000;  // global control
  parameter logic [19:0] ADDR_STATUS         = 20'h00004;  // activation status
  parameter logic [19:0] ADDR_VERSION        = 20'h0000C;  // build date
  parameter logic [19:0] ADDR_SHA_CTRL       = 20'h00100;  // sha256 enable / reset
  parameter logic [19:0] ADDR_SHA_STATUS     = 20'h00104;
  parameter logic [19:0] ADDR_SHA_PUSH       = 20'h0010C;  // write pushes, read gives level
  parameter logic [19:0] ADDR_SHA_HASH_H7    = 20'h00110;  // lowest hash word
  parameter logic [19:0] ADDR_SHA_HASH_H0    = 20'h0012C;  // highest hash word
  parameter logic [19:0] ADDR_SHA_FIFO_COUNT = 20'h00130;

  // version word, 0xYYMMDDss with ss as build serial
  parameter logic [31:0] CURRENT_DATE = 32'h16081201;

  // --------------------
  // control word, same layout for CTRL and SHA_CTRL

  typedef struct packed {
    logic [29:0] rsvd;    // reads back as written
    logic        reset;   // bit 1, one-shot on SHA_CTRL
    logic        enable;  // bit 0
  } ctrl_bits_t;

  typedef union packed {
    logic [31:0] raw;     // bus view
    ctrl_bits_t  bits;    // field view
  } ctrl_word_u;

  // --------------------
  // status bit positions

  // STATUS
  parameter int STAT_X11_ACT = 0;
  parameter int STAT_SHA_ACT = 4;

  // SHA_STATUS
  parameter int SHST_ENG_RDY  = 0;  // engine ready to start
  parameter int SHST_HASH_VLD = 1;  // engine hash output valid
  parameter int SHST_EMPTY    = 4;
  parameter int SHST_M1FULL   = 5;  // one slot or less left
  parameter int SHST_FULL     = 6;

endpackage

// ==== source/sha256_link_pkg.sv ====
package sha256_link_pkg;

  // system bus request, strobes held for one cycle
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        wen;    // write strobe
    logic        ren;    // read strobe
  } sys_req_t;

  // hash vector, index 7 is H0 (top word), index 0 is H7
  typedef logic [7:0][31:0] sha256_hash_t;

  // --------------------
  // engine link

  // engine -> register block
  typedef struct packed {
    logic ready;       // engine idle, may start
    logic hash_valid;  // level, hash output valid
    logic fifo_rd_en;  // pull one word
  } sha_eng_in_t;

  // register block -> engine
  typedef struct packed {
    logic        eng_rstn;     // active low engine reset
    logic        start;
    logic        fifo_rd_vld;  // fifo_rd_dat valid this cycle
    logic        fifo_empty;
    logic [31:0] fifo_rd_dat;
  } sha_eng_out_t;

endpackage

// ==== source/bus_reg_file.sv ====
`timescale 1ns/10ps

module bus_reg_file #(
  parameter int FIFO_ADDR_W = 9
) (
  input  logic                          clk_125mhz,
  input  logic                          rstn_125mhz,
  input  sha256_link_pkg::sys_req_t     sys_bus_i,
  input  logic                          x11_active_i,
  input  logic                          sha_active_i,
  input  logic                          eng_ready_i,
  input  logic                          hash_valid_i,
  input  sha256_link_pkg::sha256_hash_t hash_regs_i,
  input  logic [FIFO_ADDR_W:0]          fifo_level_i,
  input  logic                          fifo_empty_i,
  input  logic                          fifo_m1full_i,
  input  logic                          fifo_full_i,
  output logic [31:0]                   sys_rdata_o,
  output logic                          sys_ack_o,
  output x11_regmap_pkg::ctrl_word_u    ctrl_o,
  output x11_regmap_pkg::ctrl_word_u    sha_ctrl_o,
  output logic                          push_we_o,
  output logic [31:0]                   push_data_o
);

  logic [19:0] addr;       // only low 20 bits decoded
  logic [19:0] hash_off;   // offset from H7
  logic        hash_hit;
  logic [31:0] status_w;
  logic [31:0] sha_status_w;
  logic [31:0] level_w;

  assign addr     = sys_bus_i.addr[19:0];
  assign hash_off = addr - x11_regmap_pkg::ADDR_SHA_HASH_H7;
  assign hash_hit = (addr >= x11_regmap_pkg::ADDR_SHA_HASH_H7) &&
                    (addr <= x11_regmap_pkg::ADDR_SHA_HASH_H0) &&
                    (addr[1:0] == 2'b00);

  assign level_w = {{(31 - FIFO_ADDR_W){1'b0}}, fifo_level_i};

  // status words, unused bits read zero
  always_comb begin
    status_w     = '0;
    sha_status_w = '0;
    status_w[x11_regmap_pkg::STAT_X11_ACT]      = x11_active_i;
    status_w[x11_regmap_pkg::STAT_SHA_ACT]      = sha_active_i;
    sha_status_w[x11_regmap_pkg::SHST_ENG_RDY]  = eng_ready_i;
    sha_status_w[x11_regmap_pkg::SHST_HASH_VLD] = hash_valid_i;
    sha_status_w[x11_regmap_pkg::SHST_EMPTY]    = fifo_empty_i;
    sha_status_w[x11_regmap_pkg::SHST_M1FULL]   = fifo_m1full_i;
    sha_status_w[x11_regmap_pkg::SHST_FULL]     = fifo_full_i;
  end

  // --------------------
  // write side
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      ctrl_o.raw     <= '0;
      sha_ctrl_o.raw <= '0;
      push_we_o      <= 1'b0;
    end else begin
      sha_ctrl_o.bits.reset <= 1'b0;  // one-shot, a write below still wins
      push_we_o             <= 1'b0;
      if (sys_bus_i.wen) begin
        case (addr)
          x11_regmap_pkg::ADDR_CTRL:     ctrl_o.raw     <= sys_bus_i.wdata;
          x11_regmap_pkg::ADDR_SHA_CTRL: sha_ctrl_o.raw <= sys_bus_i.wdata;
          x11_regmap_pkg::ADDR_SHA_PUSH: push_we_o      <= 1'b1;
          default: ;                     // read-only or unmapped
        endcase
      end
    end
  end

  // push word, qualified by push_we_o
  always_ff @(posedge clk_125mhz) begin
    if (sys_bus_i.wen) begin
      push_data_o <= sys_bus_i.wdata;
    end
  end

  // --------------------
  // read mux and acknowledge
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      sys_ack_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o <= sys_bus_i.wen | sys_bus_i.ren;  // every request acked, mapped or not
      if (sys_bus_i.ren) begin
        case (addr)
          x11_regmap_pkg::ADDR_CTRL:           sys_rdata_o <= ctrl_o.raw;
          x11_regmap_pkg::ADDR_STATUS:         sys_rdata_o <= status_w;
          x11_regmap_pkg::ADDR_VERSION:        sys_rdata_o <= x11_regmap_pkg::CURRENT_DATE;
          x11_regmap_pkg::ADDR_SHA_CTRL:       sys_rdata_o <= sha_ctrl_o.raw;
          x11_regmap_pkg::ADDR_SHA_STATUS:     sys_rdata_o <= sha_status_w;
          x11_regmap_pkg::ADDR_SHA_PUSH:       sys_rdata_o <= level_w;
          x11_regmap_pkg::ADDR_SHA_FIFO_COUNT: sys_rdata_o <= level_w;
          default: begin
            if (hash_hit) begin
              sys_rdata_o <= hash_regs_i[hash_off[4:2]];  // H7 at index 0
            end else begin
              sys_rdata_o <= '0;  // unmapped
            end
          end
        endcase
      end
    end
  end

endmodule

// ==== source/activation_ctrl.sv ====
`timescale 1ns/10ps

module activation_ctrl (
  input  logic                       clk_125mhz,
  input  logic                       rstn_125mhz,
  input  x11_regmap_pkg::ctrl_word_u ctrl_i,
  input  x11_regmap_pkg::ctrl_word_u sha_ctrl_i,
  output logic                       x11_active_o,
  output logic                       sha_active_o
);

  logic sha_go;  // all conditions for a live sha256 path

  // block must already be active, sha reset overrides sha enable
  assign sha_go = x11_active_o &&
                  sha_ctrl_i.bits.enable &&
                  !sha_ctrl_i.bits.reset;

  // --------------------
  // block activation
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      x11_active_o <= 1'b0;
    end else begin
      x11_active_o <= ctrl_i.bits.enable;  // one cycle behind the write
    end
  end

  // --------------------
  // sha256 path activation, also drives engine reset
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      sha_active_o <= 1'b0;
    end else if (!sha_go) begin
      sha_active_o <= 1'b0;
    end else begin
      sha_active_o <= 1'b1;
    end
  end

  // a one-shot sha reset drops sha_active_o for a single cycle,
  // then the path comes back while enable stays set

endmodule

// ==== source/sha256_push_fifo.sv ====
`timescale 1ns/10ps

module sha256_push_fifo #(
  parameter int FIFO_ADDR_W = 9
) (
  input  logic                   clk_125mhz,
  input  logic                   rstn_125mhz,
  input  logic                   clear_n_i,    // synchronous flush, active low
  input  logic                   push_we_i,
  input  logic [31:0]            push_data_i,
  input  logic                   rd_en_i,
  output logic [31:0]            rd_data_o,
  output logic                   rd_vld_o,
  output logic [FIFO_ADDR_W:0]   level_o,
  output logic                   empty_o,
  output logic                   m1full_o,
  output logic                   full_o
);

  localparam int                 DEPTH      = 2 ** FIFO_ADDR_W;
  localparam logic [FIFO_ADDR_W:0] LVL_FULL = (FIFO_ADDR_W + 1)'(DEPTH);
  localparam logic [FIFO_ADDR_W:0] LVL_M1   = (FIFO_ADDR_W + 1)'(DEPTH - 1);

  logic [31:0]            mem [DEPTH];
  logic [FIFO_ADDR_W-1:0] wr_ptr;
  logic [FIFO_ADDR_W-1:0] rd_ptr;
  logic                   do_push;
  logic                   do_pop;

  assign empty_o  = (level_o == '0);
  assign full_o   = (level_o == LVL_FULL);
  assign m1full_o = (level_o >= LVL_M1);   // almost full includes full

  assign do_push = push_we_i && !full_o;   // push on full is dropped
  assign do_pop  = rd_en_i && !empty_o;    // read on empty ignored

  // --------------------
  // pointers and fill counter
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz || !clear_n_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level_o  <= '0;
      rd_vld_o <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      level_o  <= level_o + do_push - do_pop;
      rd_vld_o <= do_pop;                     // data one cycle after rd_en
    end
  end

  // storage and read register
  always_ff @(posedge clk_125mhz) begin
    if (do_push) mem[wr_ptr] <= push_data_i;
    if (do_pop)  rd_data_o   <= mem[rd_ptr];
  end

endmodule

// ==== source/sha256_hash_capture.sv ====
`timescale 1ns/10ps

module sha256_hash_capture (
  input  logic                          clk_125mhz,
  input  logic                          rstn_125mhz,
  input  logic                          active_i,      // sha256 path live
  input  logic                          hash_valid_i,
  input  sha256_link_pkg::sha256_hash_t hash_i,
  input  logic                          eng_ready_i,
  input  logic                          fifo_empty_i,
  output sha256_link_pkg::sha256_hash_t hash_regs_o,
  output logic                          start_o
);

  logic valid_d;     // valid, one cycle old
  logic valid_rise;

  assign valid_rise = hash_valid_i && !valid_d;

  // --------------------
  // hash capture on valid rising edge
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz || !active_i) begin
      valid_d     <= 1'b0;
      hash_regs_o <= '0;  // reads zero while path is down
    end else begin
      valid_d <= hash_valid_i;
      if (valid_rise) begin
        hash_regs_o <= hash_i;  // steady high valid keeps old words
      end
    end
  end

  // --------------------
  // start level, words waiting and engine idle
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz || !active_i) begin
      start_o <= 1'b0;
    end else begin
      start_o <= !fifo_empty_i && eng_ready_i;
    end
  end

endmodule

// ==== source/x11_regs_top.sv ====
`timescale 1ns/10ps

module x11_regs_top #(
  parameter int FIFO_ADDR_W = 9  // fifo depth 2**FIFO_ADDR_W words
) (
  input  logic                        clk_125mhz,
  input  logic                        rstn_125mhz,
  input  sha256_link_pkg::sys_req_t   sys_bus_i,
  output logic [31:0]                 sys_rdata_o,
  output logic                        sys_ack_o,
  output logic                        x11_activated_o,
  input  sha256_link_pkg::sha_eng_in_t  eng_i,
  input  sha256_link_pkg::sha256_hash_t hash_i,
  output sha256_link_pkg::sha_eng_out_t eng_o
);

  x11_regmap_pkg::ctrl_word_u   ctrl;
  x11_regmap_pkg::ctrl_word_u   sha_ctrl;
  sha256_link_pkg::sha256_hash_t hash_regs;

  logic                 x11_active;
  logic                 sha_active;
  logic                 push_we;
  logic [31:0]          push_data;
  logic [FIFO_ADDR_W:0] fifo_level;
  logic                 fifo_empty;
  logic                 fifo_m1full;
  logic                 fifo_full;
  logic                 fifo_rd_vld;
  logic [31:0]          fifo_rd_dat;
  logic                 start;

  // --------------------
  // bus registers and read mux
  bus_reg_file #(
    .FIFO_ADDR_W (FIFO_ADDR_W)
  ) u_bus_reg_file (
    .clk_125mhz    (clk_125mhz),
    .rstn_125mhz   (rstn_125mhz),
    .sys_bus_i     (sys_bus_i),
    .x11_active_i  (x11_active),
    .sha_active_i  (sha_active),
    .eng_ready_i   (eng_i.ready),
    .hash_valid_i  (eng_i.hash_valid),
    .hash_regs_i   (hash_regs),
    .fifo_level_i  (fifo_level),
    .fifo_empty_i  (fifo_empty),
    .fifo_m1full_i (fifo_m1full),
    .fifo_full_i   (fifo_full),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o),
    .ctrl_o        (ctrl),
    .sha_ctrl_o    (sha_ctrl),
    .push_we_o     (push_we),
    .push_data_o   (push_data)
  );

  activation_ctrl u_activation_ctrl (
    .clk_125mhz   (clk_125mhz),
    .rstn_125mhz  (rstn_125mhz),
    .ctrl_i       (ctrl),
    .sha_ctrl_i   (sha_ctrl),
    .x11_active_o (x11_active),
    .sha_active_o (sha_active)
  );

  // --------------------
  // data path towards the engine
  sha256_push_fifo #(
    .FIFO_ADDR_W (FIFO_ADDR_W)
  ) u_push_fifo (
    .clk_125mhz  (clk_125mhz),
    .rstn_125mhz (rstn_125mhz),
    .clear_n_i   (sha_active),  // flushed whenever sha256 path is down
    .push_we_i   (push_we),
    .push_data_i (push_data),
    .rd_en_i     (eng_i.fifo_rd_en),
    .rd_data_o   (fifo_rd_dat),
    .rd_vld_o    (fifo_rd_vld),
    .level_o     (fifo_level),
    .empty_o     (fifo_empty),
    .m1full_o    (fifo_m1full),
    .full_o      (fifo_full)
  );

  sha256_hash_capture u_hash_capture (
    .clk_125mhz   (clk_125mhz),
    .rstn_125mhz  (rstn_125mhz),
    .active_i     (sha_active),
    .hash_valid_i (eng_i.hash_valid),
    .hash_i       (hash_i),
    .eng_ready_i  (eng_i.ready),
    .fifo_empty_i (fifo_empty),
    .hash_regs_o  (hash_regs),
    .start_o      (start)
  );

  assign x11_activated_o   = x11_active;
  assign eng_o.eng_rstn    = sha_active;  // engine held in reset unless path is live
  assign eng_o.start       = start;
  assign eng_o.fifo_rd_vld = fifo_rd_vld;
  assign eng_o.fifo_empty  = fifo_empty;
  assign eng_o.fifo_rd_dat = fifo_rd_dat;

endmodule

// ==== tests/x11_regs_asserts.sv ====
`timescale 1ns/10ps

module x11_regs_asserts (
  input logic                          clk_125mhz,
  input logic                          rstn_125mhz,
  input sha256_link_pkg::sys_req_t     sys_bus_i,
  input logic                          sys_ack_i,
  input logic                          fifo_full_i,
  input logic                          fifo_empty_i,
  input sha256_link_pkg::sha_eng_out_t eng_i
);

  // --------------------
  // bus acknowledge, exactly one cycle after each request cycle
  ack_after_req : assert property (@(posedge clk_125mhz) disable iff (!rstn_125mhz)
    (sys_bus_i.wen || sys_bus_i.ren) |=> sys_ack_i)
    else $error("sys_ack_o missing one cycle after a request");

  no_stray_ack : assert property (@(posedge clk_125mhz) disable iff (!rstn_125mhz)
    !(sys_bus_i.wen || sys_bus_i.ren) |=> !sys_ack_i)
    else $error("sys_ack_o without a request");

  // fifo flags exclusive
  flags_exclusive : assert property (@(posedge clk_125mhz) disable iff (!rstn_125mhz)
    !(fifo_full_i && fifo_empty_i))
    else $error("fifo full and empty both high");

  // engine held in reset never sees start
  start_in_reset : assert property (@(posedge clk_125mhz) disable iff (!rstn_125mhz)
    !eng_i.eng_rstn |-> !eng_i.start)
    else $error("start high while eng_rstn low");

endmodule

bind x11_regs_top x11_regs_asserts u_asserts (
  .clk_125mhz   (clk_125mhz),
  .rstn_125mhz  (rstn_125mhz),
  .sys_bus_i    (sys_bus_i),
  .sys_ack_i    (sys_ack_o),
  .fifo_full_i  (fifo_full),
  .fifo_empty_i (fifo_empty),
  .eng_i        (eng_o)
);

// ==== tests/tb_x11_regs.sv ====
`timescale 1ns/10ps

module tb_x11_regs;

  localparam int FIFO_ADDR_W = 4;
  localparam int DEPTH       = 2 ** FIFO_ADDR_W;

  logic                          clk_125mhz;
  logic                          rstn_125mhz;
  sha256_link_pkg::sys_req_t     sys_bus;
  logic [31:0]                   sys_rdata;
  logic                          sys_ack;
  logic                          x11_activated;
  sha256_link_pkg::sha_eng_in_t  eng_in;    // engine model outputs
  sha256_link_pkg::sha256_hash_t hash_in;
  sha256_link_pkg::sha_eng_out_t eng_out;

  int          errors    = 0;
  int          checks    = 0;
  logic [31:0] lcg_state = 32'd18;  // seed
  logic [31:0] push_q[$];           // pushed words oldest first

  x11_regs_top #(
    .FIFO_ADDR_W (FIFO_ADDR_W)
  ) dut0 (
    .clk_125mhz      (clk_125mhz),
    .rstn_125mhz     (rstn_125mhz),
    .sys_bus_i       (sys_bus),
    .sys_rdata_o     (sys_rdata),
    .sys_ack_o       (sys_ack),
    .x11_activated_o (x11_activated),
    .eng_i           (eng_in),
    .hash_i          (hash_in),
    .eng_o           (eng_out)
  );

  initial begin
    clk_125mhz = 1'b0;
    forever #4 clk_125mhz = ~clk_125mhz;  // 125 MHz
  end

  // --------------------
  // helpers

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected SHA_STATUS from fill level and engine lines
  function automatic logic [31:0] sha_status_exp(int level, logic rdy, logic vld);
    logic [31:0] s;
    s    = '0;
    s[0] = rdy;
    s[1] = vld;
    s[4] = (level == 0);
    s[5] = (level >= DEPTH - 1);  // almost full covers full
    s[6] = (level == DEPTH);
    return s;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk_125mhz);
    #1;
  endtask

  task automatic wait_ack(input logic [19:0] a);
    int n;
    n = 0;
    while (!sys_ack && n < 8) begin
      @(posedge clk_125mhz);
      #1;
      n++;
    end
    checks++;
    if (!sys_ack) begin
      $display("no acknowledge for bus access at 0x%05h", a);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [19:0] a, input logic [31:0] d);
    idle(1);
    sys_bus.addr  = {12'h000, a};
    sys_bus.wdata = d;
    sys_bus.wen   = 1'b1;
    idle(1);
    sys_bus.wen   = 1'b0;  // single cycle strobe
    wait_ack(a);
  endtask

  task automatic bus_read(input logic [19:0] a, output logic [31:0] d);
    idle(1);
    sys_bus.addr = {12'h000, a};
    sys_bus.ren  = 1'b1;
    idle(1);
    sys_bus.ren  = 1'b0;
    wait_ack(a);
    d = sys_rdata;  // valid with ack
  endtask

  task automatic check_read(input logic [19:0] a, input logic [31:0] exp);
    logic [31:0] d;
    bus_read(a, d);
    check_value($sformatf("sys_rdata_o[0x%05h]", a), d, exp);
  endtask

  // engine model pulls one word and takes it with fifo_rd_vld
  task automatic pull_word(output logic [31:0] w);
    int n;
    n = 0;
    idle(1);
    eng_in.fifo_rd_en = 1'b1;
    idle(1);
    eng_in.fifo_rd_en = 1'b0;
    while (!eng_out.fifo_rd_vld && n < 8) begin
      idle(1);
      n++;
    end
    if (!eng_out.fifo_rd_vld) begin
      $display("fifo_rd_vld never came after a read request");
      errors++;
    end
    w = eng_out.fifo_rd_dat;
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (errors == errs_before) $display("%-14s done, no errors", name);
    else $display("%-14s done, %0d errors", name, errors - errs_before);
  endtask

  // --------------------
  // directed tests

  task automatic reset_values();
    int e0;
    e0 = errors;
    check_read(x11_regmap_pkg::ADDR_STATUS, 32'h0);
    check_read(x11_regmap_pkg::ADDR_CTRL, 32'h0);
    check_read(x11_regmap_pkg::ADDR_SHA_CTRL, 32'h0);
    check_read(x11_regmap_pkg::ADDR_VERSION, 32'h16081201);
    check_read(20'h00200, 32'h0);  // unmapped but still acked
    check_value("x11_activated_o", {31'h0, x11_activated}, 32'h0);
    end_test("reset_values", e0);
  endtask

  task automatic activation_seq();
    int e0;
    e0 = errors;
    bus_write(x11_regmap_pkg::ADDR_CTRL, 32'h1);
    idle(1);
    check_value("x11_activated_o", {31'h0, x11_activated}, 32'h1);
    check_read(x11_regmap_pkg::ADDR_STATUS, 32'h01);
    bus_write(x11_regmap_pkg::ADDR_SHA_CTRL, 32'h1);
    check_read(x11_regmap_pkg::ADDR_STATUS, 32'h11);
    check_value("eng_rstn", {31'h0, eng_out.eng_rstn}, 32'h1);
    bus_write(x11_regmap_pkg::ADDR_SHA_CTRL, 32'h3);  // enable plus one-shot reset
    check_read(x11_regmap_pkg::ADDR_SHA_CTRL, 32'h1);
    check_read(x11_regmap_pkg::ADDR_STATUS, 32'h11);  // path back up
    bus_write(x11_regmap_pkg::ADDR_CTRL, 32'h0);
    idle(1);
    check_read(x11_regmap_pkg::ADDR_STATUS, 32'h0);
    check_value("x11_activated_o", {31'h0, x11_activated}, 32'h0);
    bus_write(x11_regmap_pkg::ADDR_CTRL, 32'h1);      // live again for later tests
    idle(2);
    check_read(x11_regmap_pkg::ADDR_STATUS, 32'h11);
    end_test("activation_seq", e0);
  endtask

  task automatic push_fill();
    int          e0;
    logic [31:0] w;
    e0 = errors;
    eng_in.ready = 1'b0;  // engine holds off
    check_read(x11_regmap_pkg::ADDR_SHA_STATUS, sha_status_exp(0, 1'b0, 1'b0));
    for (int i = 1; i <= DEPTH; i++) begin
      w = lcg_next();
      bus_write(x11_regmap_pkg::ADDR_SHA_PUSH, w);
      push_q.push_back(w);
      check_read(x11_regmap_pkg::ADDR_SHA_FIFO_COUNT, i);
      if (i >= DEPTH - 1) begin
        check_read(x11_regmap_pkg::ADDR_SHA_STATUS, sha_status_exp(i, 1'b0, 1'b0));
      end
    end
    check_read(x11_regmap_pkg::ADDR_SHA_PUSH, DEPTH);
    bus_write(x11_regmap_pkg::ADDR_SHA_PUSH, lcg_next());  // dropped since fifo is full
    check_read(x11_regmap_pkg::ADDR_SHA_FIFO_COUNT, DEPTH);
    check_value("start", {31'h0, eng_out.start}, 32'h0);
    end_test("push_fill", e0);
  endtask

  task automatic drain_order();
    int          e0;
    logic [31:0] w;
    e0 = errors;
    for (int i = 0; i < DEPTH; i++) begin
      pull_word(w);
      check_value("fifo_rd_dat", w, push_q.pop_front());
    end
    idle(1);
    check_value("fifo_empty", {31'h0, eng_out.fifo_empty}, 32'h1);
    check_read(x11_regmap_pkg::ADDR_SHA_STATUS, sha_status_exp(0, 1'b0, 1'b0));
    end_test("drain_order", e0);
  endtask

  task automatic start_level();
    int          e0;
    int          n;
    logic [31:0] w;
    e0 = errors;
    n  = 0;
    eng_in.ready = 1'b1;
    repeat (4) begin
      idle(1);
      check_value("start", {31'h0, eng_out.start}, 32'h0);  // empty fifo
    end
    for (int i = 0; i < 2; i++) begin
      w = lcg_next();
      bus_write(x11_regmap_pkg::ADDR_SHA_PUSH, w);
      push_q.push_back(w);
    end
    while (!eng_out.start && n < 10) begin
      idle(1);
      n++;
    end
    checks++;
    if (!eng_out.start) begin
      $display("start never rose with words waiting and engine ready");
      errors++;
    end
    check_read(x11_regmap_pkg::ADDR_SHA_STATUS, sha_status_exp(2, 1'b1, 1'b0));
    eng_in.ready = 1'b0;
    idle(2);
    check_value("start", {31'h0, eng_out.start}, 32'h0);  // engine busy
    for (int i = 0; i < 2; i++) begin
      pull_word(w);
      check_value("fifo_rd_dat", w, push_q.pop_front());
    end
    end_test("start_level", e0);
  endtask

  task automatic hash_capture_seq();
    int                            e0;
    sha256_link_pkg::sha256_hash_t hv;
    e0 = errors;
    for (int k = 0; k < 8; k++) hv[k] = lcg_next();
    idle(1);
    hash_in           = hv;
    eng_in.hash_valid = 1'b1;
    idle(2);
    // H0 is the top word at the highest hash address
    for (int h = 0; h < 8; h++) begin
      check_read(x11_regmap_pkg::ADDR_SHA_HASH_H0 - 20'(4 * h), hv[7 - h]);
    end
    check_read(x11_regmap_pkg::ADDR_SHA_STATUS, sha_status_exp(0, 1'b0, 1'b1));
    hash_in = ~hv;  // valid stays high so no reload
    idle(2);
    for (int h = 0; h < 8; h++) begin
      check_read(x11_regmap_pkg::ADDR_SHA_HASH_H0 - 20'(4 * h), hv[7 - h]);
    end
    bus_write(x11_regmap_pkg::ADDR_SHA_CTRL, 32'h0);
    idle(2);
    for (int h = 0; h < 8; h++) begin
      check_read(x11_regmap_pkg::ADDR_SHA_HASH_H0 - 20'(4 * h), 32'h0);
    end
    eng_in.hash_valid = 1'b0;
    end_test("hash_capture", e0);
  endtask

  // --------------------
  // main sequence
  initial begin
    rstn_125mhz = 1'b0;
    sys_bus     = '0;
    eng_in      = '0;
    hash_in     = '0;
    repeat (16) @(posedge clk_125mhz);
    #1;
    rstn_125mhz = 1'b1;

    reset_values();
    activation_seq();
    push_fill();
    drain_order();
    start_level();
    hash_capture_seq();

    idle(2);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
source/x11_regmap_pkg.sv
source/sha256_link_pkg.sv
source/bus_reg_file.sv
source/activation_ctrl.sv
source/sha256_push_fifo.sv
source/sha256_hash_capture.sv
source/x11_regs_top.sv
tests/x11_regs_asserts.sv
tests/tb_x11_regs.sv
